//--- Bender.yml
package:
  name: ccd

sources:
  - logic/ccd_pkg.sv
  - logic/mc_feeder.sv
  - logic/pulse_accumulator.sv
  - logic/async_fifo_with_prefill.sv
  - logic/ccd_buffer.sv
  - logic/pe_mac.sv
  - logic/ccd_top.sv
  - target: test
    files:
      - tb/ccd_assertions.sv
      - tb/ccd_tb.sv

//--- ccd.f
logic/ccd_pkg.sv
logic/mc_feeder.sv
logic/pulse_accumulator.sv
logic/async_fifo_with_prefill.sv
logic/ccd_buffer.sv
logic/pe_mac.sv
logic/ccd_top.sv
tb/ccd_assertions.sv
tb/ccd_tb.sv

//--- logic/async_fifo_with_prefill.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_with_prefill import ccd_pkg::*; #(
    parameter int data_width = DATA_WIDTH
) (
    input  wire                   wr_clk,
    input  wire                   rd_clk,
    input  wire                   rst,
    input  wire                   wr_en,
    input  wire  [data_width-1:0] wr_data,
    output logic                  full,
    output logic                  pre_fill_done,
    input  wire                   rd_en,
    output logic [data_width-1:0] rd_data,
    output logic                  empty,
    output logic                  pre_fill_done_sync
);

    // Gray to binary for a synchronized pointer
    function automatic logic [PTR_WIDTH-1:0] gray_to_bin(input logic [PTR_WIDTH-1:0] gray);
        logic [PTR_WIDTH-1:0] bin;
        bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Dual clock storage
    logic [data_width-1:0] mem [FIFO_DEPTH];

    // Read pointer in Gray, crosses into the write domain
    logic [PTR_WIDTH-1:0] rd_gray;

    ////////////////////////////////////////
    // Write domain
    ////////////////////////////////////////

    logic [PTR_WIDTH-1:0] wr_bin;
    logic [PTR_WIDTH-1:0] wr_bin_next;
    logic [PTR_WIDTH-1:0] wr_gray;
    logic [PTR_WIDTH-1:0] rd_gray_meta;
    logic [PTR_WIDTH-1:0] rd_gray_sync;
    logic [PTR_WIDTH-1:0] wr_level;
    logic [PTR_WIDTH-1:0] wr_level_next;

    assign wr_bin_next = wr_bin + PTR_WIDTH'(wr_en);

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_bin[PTR_WIDTH-2:0]] <= wr_data;
        end
    end

    // Binary pointer for addressing, Gray copy for the crossing
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            wr_bin       <= wr_bin_next;
            wr_gray      <= wr_bin_next ^ (wr_bin_next >> 1);
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    // Occupancy seen from the write side, never below the true value
    assign wr_level      = wr_bin - gray_to_bin(rd_gray_sync);
    assign wr_level_next = wr_bin_next - gray_to_bin(rd_gray_sync);

    // Full looks one write ahead so a beat accepted now still fits
    assign full          = (wr_level_next >= PTR_WIDTH'(FIFO_DEPTH));
    assign pre_fill_done = (wr_level >= PTR_WIDTH'(PREFILL_LEVEL));

    ////////////////////////////////////////
    // Read domain
    ////////////////////////////////////////

    logic [PTR_WIDTH-1:0] rd_bin;
    logic [PTR_WIDTH-1:0] rd_bin_next;
    logic [PTR_WIDTH-1:0] wr_gray_meta;
    logic [PTR_WIDTH-1:0] wr_gray_sync;
    logic [PTR_WIDTH-1:0] rd_level;

    assign rd_bin_next = rd_bin + PTR_WIDTH'(rd_en);

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            rd_bin       <= rd_bin_next;
            rd_gray      <= rd_bin_next ^ (rd_bin_next >> 1);
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    // Head entry, first word fall through
    assign rd_data = mem[rd_bin[PTR_WIDTH-2:0]];

    assign rd_level           = gray_to_bin(wr_gray_sync) - rd_bin;
    assign empty              = (rd_level == '0);
    assign pre_fill_done_sync = (rd_level >= PTR_WIDTH'(PREFILL_LEVEL));

endmodule

`default_nettype wire

//--- logic/ccd_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ccd_buffer import ccd_pkg::*; (
    input  wire                   bus_clk,
    input  wire                   pe_clk,
    input  wire                   rst,
    input  wire                   pe_en,
    input  wire  [DATA_WIDTH-1:0] ifmap_data,
    input  wire  [DATA_WIDTH-1:0] fltr_data,
    input  wire  [PSUM_WIDTH-1:0] psum_data,
    output logic                  overflow,
    output logic                  empty,
    output logic                  buffer_busy,
    output logic                  buffer_busy_sync,
    output logic                  rd_en,
    output logic [DATA_WIDTH-1:0] pe_ifmap,
    output logic [DATA_WIDTH-1:0] pe_fltr,
    output logic [PSUM_WIDTH-1:0] pe_psum
);

    // Per stream status
    logic ifmap_full;
    logic fltr_full;
    logic psum_full;
    logic ifmap_empty;
    logic fltr_empty;
    logic psum_empty;
    logic ifmap_prefill;
    logic fltr_prefill;
    logic psum_prefill;
    logic ifmap_prefill_sync;
    logic fltr_prefill_sync;
    logic psum_prefill_sync;

    // FIFO heads before gating
    logic [DATA_WIDTH-1:0] ifmap_head;
    logic [DATA_WIDTH-1:0] fltr_head;
    logic [PSUM_WIDTH-1:0] psum_head;

    logic rd_pending;

    ////////////////////////////////////////
    // Strobe crossing
    ////////////////////////////////////////

    pulse_accumulator rd_en_synchronizer (
        .fast_clk   (bus_clk),
        .slow_clk   (pe_clk),
        .rst        (rst),
        .fast_pulse (pe_en),
        .take       (rd_en),
        .rd_pending (rd_pending)
    );

    // Empty only guards, pointer sync keeps pace with the strobe count
    assign rd_en = rd_pending & ~empty;

    ////////////////////////////////////////
    // Stream FIFOs
    ////////////////////////////////////////

    async_fifo_with_prefill #(.data_width(DATA_WIDTH)) ifmap_fifo (
        .wr_clk (bus_clk), .rd_clk (pe_clk), .rst (rst),
        .wr_en (pe_en), .wr_data (ifmap_data), .full (ifmap_full),
        .pre_fill_done (ifmap_prefill), .rd_en (rd_en), .rd_data (ifmap_head),
        .empty (ifmap_empty), .pre_fill_done_sync (ifmap_prefill_sync)
    );

    // Filter has its own FIFO too, no direct crossing
    async_fifo_with_prefill #(.data_width(DATA_WIDTH)) fltr_fifo (
        .wr_clk (bus_clk), .rd_clk (pe_clk), .rst (rst),
        .wr_en (pe_en), .wr_data (fltr_data), .full (fltr_full),
        .pre_fill_done (fltr_prefill), .rd_en (rd_en), .rd_data (fltr_head),
        .empty (fltr_empty), .pre_fill_done_sync (fltr_prefill_sync)
    );

    async_fifo_with_prefill #(.data_width(PSUM_WIDTH)) psum_fifo (
        .wr_clk (bus_clk), .rd_clk (pe_clk), .rst (rst),
        .wr_en (pe_en), .wr_data (psum_data), .full (psum_full),
        .pre_fill_done (psum_prefill), .rd_en (rd_en), .rd_data (psum_head),
        .empty (psum_empty), .pre_fill_done_sync (psum_prefill_sync)
    );

    // Merged status
    assign overflow         = ifmap_full | fltr_full | psum_full;
    assign empty            = ifmap_empty | fltr_empty | psum_empty;
    assign buffer_busy      = ~(ifmap_prefill & fltr_prefill & psum_prefill);
    assign buffer_busy_sync = ~(ifmap_prefill_sync & fltr_prefill_sync & psum_prefill_sync);

    // Zero outside a read
    assign pe_ifmap = rd_en ? ifmap_head : '0;
    assign pe_fltr  = rd_en ? fltr_head  : '0;
    assign pe_psum  = rd_en ? psum_head  : '0;

endmodule

`default_nettype wire

//--- logic/ccd_pkg.sv
`default_nettype none

////////////////////////////////////////
// Shared widths and FIFO sizing
////////////////////////////////////////

package ccd_pkg;

    // Input map and filter word width
    localparam int DATA_WIDTH = 8;

    // Partial sum carries a full product
    localparam int PSUM_WIDTH = 2 * DATA_WIDTH;

    // Entries per stream FIFO
    localparam int FIFO_DEPTH = 16;

    // Address bits plus one wrap bit
    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH) + 1;

    // Occupancy that ends the prefill phase
    localparam int PREFILL_LEVEL = 4;

    // Pending strobe counter in the accumulator
    localparam int COUNT_WIDTH = 5;

endpackage

`default_nettype wire

//--- logic/ccd_top.sv
`timescale 1ns/1ps
`default_nettype none

module ccd_top import ccd_pkg::*; (
    input  wire                   bus_clk,
    input  wire                   pe_clk,
    input  wire                   rst,
    input  wire                   in_valid,
    input  wire  [DATA_WIDTH-1:0] in_ifmap,
    input  wire  [DATA_WIDTH-1:0] in_fltr,
    input  wire  [PSUM_WIDTH-1:0] in_psum,
    output logic                  out_valid,
    output logic [PSUM_WIDTH-1:0] out_psum,
    output logic                  drop_error,
    output logic                  overflow,
    output logic                  empty,
    output logic                  buffer_busy,
    output logic                  buffer_busy_sync
);

    // Bus side beat
    logic                  pe_en;
    logic [DATA_WIDTH-1:0] ifmap_data;
    logic [DATA_WIDTH-1:0] fltr_data;
    logic [PSUM_WIDTH-1:0] psum_data;

    // PE side read
    logic                  rd_en;
    logic [DATA_WIDTH-1:0] pe_ifmap;
    logic [DATA_WIDTH-1:0] pe_fltr;
    logic [PSUM_WIDTH-1:0] pe_psum;

    mc_feeder mc_feeder_inst (
        .bus_clk (bus_clk), .rst (rst), .in_valid (in_valid),
        .in_ifmap (in_ifmap), .in_fltr (in_fltr), .in_psum (in_psum),
        .overflow (overflow), .pe_en (pe_en), .ifmap_data (ifmap_data),
        .fltr_data (fltr_data), .psum_data (psum_data), .drop_error (drop_error)
    );

    ccd_buffer ccd_buffer_inst (
        .bus_clk (bus_clk), .pe_clk (pe_clk), .rst (rst), .pe_en (pe_en),
        .ifmap_data (ifmap_data), .fltr_data (fltr_data), .psum_data (psum_data),
        .overflow (overflow), .empty (empty), .buffer_busy (buffer_busy),
        .buffer_busy_sync (buffer_busy_sync), .rd_en (rd_en),
        .pe_ifmap (pe_ifmap), .pe_fltr (pe_fltr), .pe_psum (pe_psum)
    );

    pe_mac pe_mac_inst (
        .pe_clk (pe_clk), .rst (rst), .rd_en (rd_en), .pe_ifmap (pe_ifmap),
        .pe_fltr (pe_fltr), .pe_psum (pe_psum),
        .out_valid (out_valid), .out_psum (out_psum)
    );

endmodule

`default_nettype wire

//--- logic/mc_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module mc_feeder import ccd_pkg::*; (
    input  wire                   bus_clk,
    input  wire                   rst,
    input  wire                   in_valid,
    input  wire  [DATA_WIDTH-1:0] in_ifmap,
    input  wire  [DATA_WIDTH-1:0] in_fltr,
    input  wire  [PSUM_WIDTH-1:0] in_psum,
    input  wire                   overflow,
    output logic                  pe_en,
    output logic [DATA_WIDTH-1:0] ifmap_data,
    output logic [DATA_WIDTH-1:0] fltr_data,
    output logic [PSUM_WIDTH-1:0] psum_data,
    output logic                  drop_error
);

    // Beat goes in only while every stream FIFO has room
    logic accept;

    assign accept = in_valid & ~overflow;

    // Strobe and sticky drop flag
    always_ff @(posedge bus_clk) begin
        if (rst) begin
            pe_en      <= 1'b0;
            drop_error <= 1'b0;
        end else begin
            pe_en <= accept;
            // Lost beat, held until reset
            if (in_valid && overflow) begin
                drop_error <= 1'b1;
            end
        end
    end

    // Beat words, valid together with pe_en
    always_ff @(posedge bus_clk) begin
        if (accept) begin
            ifmap_data <= in_ifmap;
            fltr_data  <= in_fltr;
            psum_data  <= in_psum;
        end
    end

endmodule

`default_nettype wire

//--- logic/pe_mac.sv
`timescale 1ns/1ps
`default_nettype none

module pe_mac import ccd_pkg::*; (
    input  wire                   pe_clk,
    input  wire                   rst,
    input  wire                   rd_en,
    input  wire  [DATA_WIDTH-1:0] pe_ifmap,
    input  wire  [DATA_WIDTH-1:0] pe_fltr,
    input  wire  [PSUM_WIDTH-1:0] pe_psum,
    output logic                  out_valid,
    output logic [PSUM_WIDTH-1:0] out_psum
);

    // Signed product, sign extended operands
    logic signed [PSUM_WIDTH-1:0] product;

    assign product = $signed(pe_ifmap) * $signed(pe_fltr);

    // Result pulse one cycle after the read
    always_ff @(posedge pe_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    // Accumulate wraps at PSUM_WIDTH
    always_ff @(posedge pe_clk) begin
        if (rd_en) begin
            out_psum <= product + $signed(pe_psum);
        end
    end

endmodule

`default_nettype wire

//--- logic/pulse_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_accumulator import ccd_pkg::*; (
    input  wire  fast_clk,
    input  wire  slow_clk,
    input  wire  rst,
    input  wire  fast_pulse,
    input  wire  take,
    output logic rd_pending
);

    ////////////////////////////////////////
    // Fast domain strobe counter
    ////////////////////////////////////////

    logic [COUNT_WIDTH-1:0] fast_bin;
    logic [COUNT_WIDTH-1:0] fast_bin_next;
    logic [COUNT_WIDTH-1:0] fast_gray;

    assign fast_bin_next = fast_bin + COUNT_WIDTH'(fast_pulse);

    // Gray copy is what crosses, one bit changes per strobe
    always_ff @(posedge fast_clk) begin
        if (rst) begin
            fast_bin  <= '0;
            fast_gray <= '0;
        end else begin
            fast_bin  <= fast_bin_next;
            fast_gray <= fast_bin_next ^ (fast_bin_next >> 1);
        end
    end

    ////////////////////////////////////////
    // Slow domain sync and take counter
    ////////////////////////////////////////

    logic [COUNT_WIDTH-1:0] gray_meta;
    logic [COUNT_WIDTH-1:0] gray_sync;
    logic [COUNT_WIDTH-1:0] sync_bin;
    logic [COUNT_WIDTH-1:0] taken;

    // Two flops, same depth as the FIFO pointer sync
    always_ff @(posedge slow_clk) begin
        if (rst) begin
            gray_meta <= '0;
            gray_sync <= '0;
            taken     <= '0;
        end else begin
            gray_meta <= fast_gray;
            gray_sync <= gray_meta;
            taken     <= taken + COUNT_WIDTH'(take);
        end
    end

    // Gray back to binary, msb first
    always_comb begin
        sync_bin[COUNT_WIDTH-1] = gray_sync[COUNT_WIDTH-1];
        for (int i = COUNT_WIDTH - 2; i >= 0; i--) begin
            sync_bin[i] = sync_bin[i+1] ^ gray_sync[i];
        end
    end

    // Strobes seen but not yet committed
    assign rd_pending = (sync_bin != taken);

endmodule

`default_nettype wire

//--- tb/ccd_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ccd_assertions import ccd_pkg::*; (
    input wire bus_clk,
    input wire pe_clk,
    input wire rst,
    input wire pe_en,
    input wire rd_en,
    input wire rd_pending,
    input wire empty
);

    // Failed assertion count
    int error_count = 0;

    // Beats written and read, each counted on its own clock
    int unsigned writes_seen;
    int unsigned reads_seen;

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            writes_seen <= 0;
        end else if (pe_en) begin
            writes_seen <= writes_seen + 1;
        end
    end

    always_ff @(posedge pe_clk) begin
        if (rst) begin
            reads_seen <= 0;
        end else if (rd_en) begin
            reads_seen <= reads_seen + 1;
        end
    end

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////

    // A write needs a free entry in the true occupancy
    write_with_room: assert property (@(posedge bus_clk) disable iff (rst)
        pe_en |-> (writes_seen - reads_seen < FIFO_DEPTH))
    else begin
        $error("stream FIFO written while full");
        error_count++;
    end

    ////////////////////////////////////////
    // PE side
    ////////////////////////////////////////

    // A pending strobe always finds its data, empty only guards
    read_not_empty: assert property (@(posedge pe_clk) disable iff (rst)
        rd_pending |-> !empty)
    else begin
        $error("strobe pending while stream FIFO empty");
        error_count++;
    end

    // Back to back reads only while written beats remain
    read_strobe_length: assert property (@(posedge pe_clk) disable iff (rst)
        (rd_en && $past(rd_en)) |-> (writes_seen > reads_seen))
    else begin
        $error("read strobe held with no strobe pending");
        error_count++;
    end

endmodule

bind ccd_buffer ccd_assertions ccd_assertions_inst (
    .bus_clk    (bus_clk),
    .pe_clk     (pe_clk),
    .rst        (rst),
    .pe_en      (pe_en),
    .rd_en      (rd_en),
    .rd_pending (rd_pending),
    .empty      (empty)
);

`default_nettype wire

//--- tb/ccd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ccd_tb import ccd_pkg::*; ();

    localparam int SEED       = 85009;
    localparam int N_SPARSE   = 20;
    localparam int MAX_GAP    = 8;
    localparam int LONG_BURST = 48;
    localparam int SETTLE     = 12;
    // Beat and idle cycles driven over all tests
    localparam int STIM_CYCLES    = N_SPARSE * (MAX_GAP + 1) + 3 + 4 + 2 * 10 + LONG_BURST;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic bus_clk = 1'b0;
    logic pe_clk  = 1'b0;
    logic rst;
    logic in_valid;
    logic [DATA_WIDTH-1:0] in_ifmap;
    logic [DATA_WIDTH-1:0] in_fltr;
    logic [PSUM_WIDTH-1:0] in_psum;
    logic out_valid;
    logic [PSUM_WIDTH-1:0] out_psum;
    logic drop_error;
    logic overflow;
    logic empty;
    logic buffer_busy;
    logic buffer_busy_sync;

    // Reference model, one entry per accepted beat
    logic [PSUM_WIDTH-1:0] expected_q[$];
    int  accepted;
    int  dropped;
    int  received;
    int  cycle_count;
    bit  busy_low_seen;
    bit  busy_sync_low_seen;
    bit  overflow_seen;

    ccd_top ccd_top_inst (
        .bus_clk (bus_clk), .pe_clk (pe_clk), .rst (rst), .in_valid (in_valid),
        .in_ifmap (in_ifmap), .in_fltr (in_fltr), .in_psum (in_psum),
        .out_valid (out_valid), .out_psum (out_psum), .drop_error (drop_error),
        .overflow (overflow), .empty (empty), .buffer_busy (buffer_busy),
        .buffer_busy_sync (buffer_busy_sync)
    );

    // 8 ns bus clock, 20 ns PE clock
    initial forever #4 bus_clk = ~bus_clk;
    initial forever #10 pe_clk = ~pe_clk;

    ////////////////////////////////////////
    // Model and helpers
    ////////////////////////////////////////

    // Signed MAC, wrapped to the partial sum width
    function automatic logic [PSUM_WIDTH-1:0] mac_result(input logic [DATA_WIDTH-1:0] a,
                                                         input logic [DATA_WIDTH-1:0] b,
                                                         input logic [PSUM_WIDTH-1:0] p);
        int sum;
        sum = int'($signed(a)) * int'($signed(b)) + int'($signed(p));
        return PSUM_WIDTH'(sum);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // One random beat; overflow is stable until the next rising edge
    task automatic drive_beat();
        @(negedge bus_clk);
        in_valid = 1'b1;
        in_ifmap = DATA_WIDTH'($urandom);
        in_fltr  = DATA_WIDTH'($urandom);
        in_psum  = PSUM_WIDTH'($urandom);
        if (overflow) begin
            dropped++;
        end else begin
            expected_q.push_back(mac_result(in_ifmap, in_fltr, in_psum));
            accepted++;
        end
    endtask

    // Idle cycle, data left random on purpose
    task automatic drive_idle();
        @(negedge bus_clk);
        in_valid = 1'b0;
        in_ifmap = DATA_WIDTH'($urandom);
        in_psum  = PSUM_WIDTH'($urandom);
    endtask

    // Wait for every accepted beat, then let the pointers resync
    task automatic drain_outputs();
        drive_idle();
        while (expected_q.size() != 0) begin
            @(negedge bus_clk);
        end
        repeat (SETTLE) @(negedge bus_clk);
    endtask

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    // Results in order against the model queue
    always @(negedge pe_clk) begin
        if (!rst && out_valid) begin
            if (expected_q.size() == 0) begin
                $display("A result came out with no accepted beat left to match it");
                $display("Test failed");
                $fatal(1, "unexpected output");
            end else begin
                compare_value("out_psum", expected_q.pop_front(), out_psum);
                received++;
            end
        end
    end

    // Status seen at any point of a test
    always @(negedge bus_clk) begin
        if (!rst && !buffer_busy) begin
            busy_low_seen = 1'b1;
        end
        if (!rst && overflow) begin
            overflow_seen = 1'b1;
        end
    end

    // PE side prefill status
    always @(negedge pe_clk) begin
        if (!rst && !buffer_busy_sync) begin
            busy_sync_low_seen = 1'b1;
        end
    end

    // Watchdog for hangs and bound assertion failures
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge bus_clk);
            cycle_count++;
            if (ccd_top_inst.ccd_buffer_inst.ccd_assertions_inst.error_count != 0) begin
                $display("An assertion on the crossing buffer fired");
                $display("Test failed");
                $fatal(1, "assertion failure");
            end else if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d bus cycles, the outputs stopped arriving",
                         cycle_count);
                $display("Test failed");
                $fatal(1, "timeout");
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst                = 1'b1;
        in_valid           = 1'b0;
        in_ifmap           = '0;
        in_fltr            = '0;
        in_psum            = '0;
        accepted           = 0;
        dropped            = 0;
        received           = 0;
        busy_low_seen      = 1'b0;
        busy_sync_low_seen = 1'b0;
        overflow_seen      = 1'b0;

        // Two PE cycles span five bus cycles
        repeat (2) @(posedge pe_clk);
        @(negedge bus_clk);
        rst = 1'b0;
        repeat (2) @(negedge bus_clk);

        // Idle state after reset
        compare_value("reset_empty", 1, empty);
        compare_value("reset_busy", 1, buffer_busy);
        compare_value("reset_busy_sync", 1, buffer_busy_sync);
        compare_value("reset_out_valid", 0, out_valid);
        compare_value("reset_overflow", 0, overflow);
        compare_value("reset_drop_error", 0, drop_error);

        // Sparse beats, 5 to 9 bus cycles apart
        for (int i = 0; i < N_SPARSE; i++) begin
            drive_beat();
            repeat (4 + $urandom_range(0, MAX_GAP - 4)) drive_idle();
        end
        drain_outputs();

        // Three in flight stays under the prefill level
        busy_low_seen = 1'b0;
        repeat (3) drive_beat();
        drain_outputs();
        compare_value("burst3_busy_low", 0, busy_low_seen);

        // Four in flight reaches it
        repeat (4) drive_beat();
        drain_outputs();
        compare_value("burst4_busy_low", 1, busy_low_seen);

        // Full rate, ten at a time, fits the FIFO
        overflow_seen      = 1'b0;
        busy_sync_low_seen = 1'b0;
        repeat (2) begin
            repeat (10) drive_beat();
            drain_outputs();
        end
        compare_value("burst10_overflow", 0, overflow_seen);
        compare_value("burst10_drop_error", 0, drop_error);
        compare_value("burst10_dropped", 0, dropped);
        compare_value("burst10_busy_sync_low", 1, busy_sync_low_seen);

        // Long full rate burst overruns the FIFO
        repeat (LONG_BURST) drive_beat();
        drain_outputs();
        compare_value("long_overflow", 1, overflow_seen);
        compare_value("long_drop_error", 1, drop_error);
        compare_value("long_dropped", 1, dropped > 0);

        // Drained
        compare_value("drain_queue", 0, expected_q.size());
        compare_value("drain_empty", 1, empty);
        compare_value("drain_count", accepted, received);

        if (ccd_top_inst.ccd_buffer_inst.ccd_assertions_inst.error_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "errors recorded during the run");
        end
    end

endmodule

`default_nettype wire
